/* hdl/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Data path and address width
`define MIPS_NBITS 32

// Register index width
`define MIPS_RNBITS 5

// Register file depth
`define MIPS_NREGS 32

`endif

/* hdl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    // ALUOp as carried through ID/EX
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'b00,
        ALUOP_SUB   = 2'b01,
        ALUOP_FUNCT = 2'b10,
        ALUOP_NONE  = 2'b11
    } alu_op_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_ctl_e;

    // Load filter size, value 2 is not used
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd3
    } mem_size_e;

endpackage

`default_nettype wire

/* hdl/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module decode_unit
    import mips_pkg::*;
(
    input  logic [`MIPS_NBITS-1:0]  i_instruction,
    output logic [`MIPS_RNBITS-1:0] o_rs,
    output logic [`MIPS_RNBITS-1:0] o_rt,
    output logic [`MIPS_RNBITS-1:0] o_rd,
    output logic [`MIPS_NBITS-1:0]  o_extension,
    output logic                    o_alu_src,
    output alu_op_e                 o_alu_op,
    output logic                    o_reg_dst,
    output logic                    o_branch,
    output logic                    o_mem_write,
    output logic                    o_mem_read,
    output mem_size_e               o_mem_size,
    output logic                    o_mem_to_reg,
    output logic                    o_reg_write
);

    opcode_e opcode;

    assign opcode = opcode_e'(i_instruction[31:26]);

    assign o_rs = i_instruction[25:21];
    assign o_rt = i_instruction[20:16];
    assign o_rd = i_instruction[15:11];

    assign o_extension = {{(`MIPS_NBITS-16){i_instruction[15]}}, i_instruction[15:0]};

    always_comb
    begin
        // Bubble unless the opcode is known
        o_alu_src    = 1'b0;
        o_alu_op     = ALUOP_NONE;
        o_reg_dst    = 1'b0;
        o_branch     = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_size   = SIZE_BYTE;
        o_mem_to_reg = 1'b0;
        o_reg_write  = 1'b0;
        case (opcode)
            OP_RTYPE:
            begin
                o_alu_op    = ALUOP_FUNCT;
                o_reg_dst   = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_ADDI:
            begin
                o_alu_op    = ALUOP_ADD;
                o_alu_src   = 1'b1;
                o_reg_write = 1'b1;
            end
            OP_LB, OP_LH, OP_LW:
            begin
                o_alu_op     = ALUOP_ADD;
                o_alu_src    = 1'b1;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
                o_reg_write  = 1'b1;
                o_mem_size   = (opcode == OP_LB) ? SIZE_BYTE :
                               (opcode == OP_LH) ? SIZE_HALF : SIZE_WORD;
            end
            OP_SW:
            begin
                o_alu_op    = ALUOP_ADD;
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
                o_mem_size  = SIZE_WORD;
            end
            OP_BEQ:
            begin
                o_alu_op = ALUOP_SUB;
                o_branch = 1'b1;
            end
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module register_file
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic [`MIPS_RNBITS-1:0] i_rd_addr1,
    input  logic [`MIPS_RNBITS-1:0] i_rd_addr2,
    input  logic                    i_wr_en,
    input  logic [`MIPS_RNBITS-1:0] i_wr_addr,
    input  logic [`MIPS_NBITS-1:0]  i_wr_data,
    output logic [`MIPS_NBITS-1:0]  o_rd_data1,
    output logic [`MIPS_NBITS-1:0]  o_rd_data2
);

    logic [`MIPS_NBITS-1:0] regs [`MIPS_NREGS];

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < `MIPS_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wr_en && (i_wr_addr != '0))
        begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // No bypass, a same-cycle write is seen next cycle
    assign o_rd_data1 = (i_rd_addr1 == '0) ? '0 : regs[i_rd_addr1];
    assign o_rd_data2 = (i_rd_addr2 == '0) ? '0 : regs[i_rd_addr2];

    a_reg_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n) regs[0] == '0)
        else $error("register zero was written");

endmodule

`default_nettype wire

/* hdl/etapa_id_ex.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module etapa_id_ex
    import mips_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic [`MIPS_NBITS-1:0]  i_pc4,
    input  logic [`MIPS_NBITS-1:0]  i_instruction,
    input  logic [`MIPS_NBITS-1:0]  i_registro1,
    input  logic [`MIPS_NBITS-1:0]  i_registro2,
    input  logic [`MIPS_NBITS-1:0]  i_extension,
    input  logic [`MIPS_RNBITS-1:0] i_rt,
    input  logic [`MIPS_RNBITS-1:0] i_rd,
    // EX control
    input  logic                    i_alu_src,
    input  alu_op_e                 i_alu_op,
    input  logic                    i_reg_dst,
    // M control
    input  logic                    i_branch,
    input  logic                    i_mem_write,
    input  logic                    i_mem_read,
    input  mem_size_e               i_mem_size,
    // WB control
    input  logic                    i_mem_to_reg,
    input  logic                    i_reg_write,
    output logic [`MIPS_NBITS-1:0]  o_pc4,
    output logic [`MIPS_NBITS-1:0]  o_instruction,
    output logic [`MIPS_NBITS-1:0]  o_registro1,
    output logic [`MIPS_NBITS-1:0]  o_registro2,
    output logic [`MIPS_NBITS-1:0]  o_extension,
    output logic [`MIPS_RNBITS-1:0] o_rt,
    output logic [`MIPS_RNBITS-1:0] o_rd,
    output logic                    o_alu_src,
    output alu_op_e                 o_alu_op,
    output logic                    o_reg_dst,
    output logic                    o_branch,
    output logic                    o_mem_write,
    output logic                    o_mem_read,
    output mem_size_e               o_mem_size,
    output logic                    o_mem_to_reg,
    output logic                    o_reg_write
);

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_pc4         <= '0;
            o_instruction <= '0;
            o_registro1   <= '0;
            o_registro2   <= '0;
            o_extension   <= '0;
            o_rt          <= '0;
            o_rd          <= '0;
            // Reset loads a bubble
            o_alu_src     <= 1'b0;
            o_alu_op      <= ALUOP_NONE;
            o_reg_dst     <= 1'b0;
            o_branch      <= 1'b0;
            o_mem_write   <= 1'b0;
            o_mem_read    <= 1'b0;
            o_mem_size    <= SIZE_BYTE;
            o_mem_to_reg  <= 1'b0;
            o_reg_write   <= 1'b0;
        end
        else
        begin
            o_pc4         <= i_pc4;
            o_instruction <= i_instruction;
            o_registro1   <= i_registro1;
            o_registro2   <= i_registro2;
            o_extension   <= i_extension;
            o_rt          <= i_rt;
            o_rd          <= i_rd;
            // EX
            o_alu_src     <= i_alu_src;
            o_alu_op      <= i_alu_op;
            o_reg_dst     <= i_reg_dst;
            // M
            o_branch      <= i_branch;
            o_mem_write   <= i_mem_write;
            o_mem_read    <= i_mem_read;
            o_mem_size    <= i_mem_size;
            // WB
            o_mem_to_reg  <= i_mem_to_reg;
            o_reg_write   <= i_reg_write;
        end
    end

    a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_mem_read && o_mem_write))
        else $error("load and store issued together");

    a_wb_from_mem: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_mem_to_reg |-> o_mem_read)
        else $error("mem_to_reg without a load");

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module execute_stage
    import mips_pkg::*;
(
    input  logic [`MIPS_NBITS-1:0]  i_pc4,
    input  logic [`MIPS_NBITS-1:0]  i_registro1,
    input  logic [`MIPS_NBITS-1:0]  i_registro2,
    input  logic [`MIPS_NBITS-1:0]  i_extension,
    input  logic [`MIPS_NBITS-1:0]  i_instruction,
    input  logic [`MIPS_RNBITS-1:0] i_rt,
    input  logic [`MIPS_RNBITS-1:0] i_rd,
    input  logic                    i_alu_src,
    input  logic                    i_reg_dst,
    input  alu_op_e                 i_alu_op,
    output logic [`MIPS_NBITS-1:0]  o_alu_result,
    output logic                    o_zero,
    output logic [`MIPS_NBITS-1:0]  o_branch_target,
    output logic [`MIPS_NBITS-1:0]  o_store_data,
    output logic [`MIPS_RNBITS-1:0] o_write_reg
);

    localparam logic [5:0] FUNCT_ADD = 6'h20;
    localparam logic [5:0] FUNCT_SUB = 6'h22;
    localparam logic [5:0] FUNCT_AND = 6'h24;
    localparam logic [5:0] FUNCT_OR  = 6'h25;
    localparam logic [5:0] FUNCT_SLT = 6'h2A;

    alu_ctl_e               alu_ctl;
    logic [5:0]             funct;
    logic [`MIPS_NBITS-1:0] operand_b;
    logic                   less;

    assign funct = i_instruction[5:0];

    always_comb
    begin
        case (i_alu_op)
            ALUOP_SUB:   alu_ctl = ALU_SUB;
            ALUOP_FUNCT:
            begin
                case (funct)
                    FUNCT_SUB: alu_ctl = ALU_SUB;
                    FUNCT_AND: alu_ctl = ALU_AND;
                    FUNCT_OR:  alu_ctl = ALU_OR;
                    FUNCT_SLT: alu_ctl = ALU_SLT;
                    FUNCT_ADD: alu_ctl = ALU_ADD;
                    default:   alu_ctl = ALU_ADD;
                endcase
            end
            default:     alu_ctl = ALU_ADD;
        endcase
    end

    assign operand_b = i_alu_src ? i_extension : i_registro2;
    assign less      = $signed(i_registro1) < $signed(operand_b);

    always_comb
    begin
        case (alu_ctl)
            ALU_SUB: o_alu_result = i_registro1 - operand_b;
            ALU_AND: o_alu_result = i_registro1 & operand_b;
            ALU_OR:  o_alu_result = i_registro1 | operand_b;
            ALU_SLT: o_alu_result = {{(`MIPS_NBITS-1){1'b0}}, less};
            default: o_alu_result = i_registro1 + operand_b;
        endcase
    end

    assign o_zero          = (o_alu_result == '0);
    assign o_branch_target = i_pc4 + {i_extension[`MIPS_NBITS-3:0], 2'b00};
    assign o_store_data    = i_registro2;
    assign o_write_reg     = i_reg_dst ? i_rd : i_rt;

endmodule

`default_nettype wire

/* hdl/id_ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module id_ex_top
    import mips_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic [`MIPS_NBITS-1:0]  i_instruction,
    input  logic [`MIPS_NBITS-1:0]  i_pc4,
    input  logic                    i_wb_en,
    input  logic [`MIPS_RNBITS-1:0] i_wb_addr,
    input  logic [`MIPS_NBITS-1:0]  i_wb_data,
    output logic [`MIPS_NBITS-1:0]  o_alu_result,
    output logic                    o_zero,
    output logic [`MIPS_NBITS-1:0]  o_branch_target,
    output logic [`MIPS_NBITS-1:0]  o_store_data,
    output logic [`MIPS_RNBITS-1:0] o_write_reg,
    output logic                    o_branch,
    output logic                    o_mem_write,
    output logic                    o_mem_read,
    output mem_size_e               o_mem_size,
    output logic                    o_mem_to_reg,
    output logic                    o_reg_write
);

    // Decode side
    logic [`MIPS_RNBITS-1:0] dec_rs;
    logic [`MIPS_RNBITS-1:0] dec_rt;
    logic [`MIPS_RNBITS-1:0] dec_rd;
    logic [`MIPS_NBITS-1:0]  dec_extension;
    logic                    dec_alu_src;
    alu_op_e                 dec_alu_op;
    logic                    dec_reg_dst;
    logic                    dec_branch;
    logic                    dec_mem_write;
    logic                    dec_mem_read;
    mem_size_e               dec_mem_size;
    logic                    dec_mem_to_reg;
    logic                    dec_reg_write;
    logic [`MIPS_NBITS-1:0]  rd_data1;
    logic [`MIPS_NBITS-1:0]  rd_data2;

    // Execute side
    logic [`MIPS_NBITS-1:0]  ex_pc4;
    logic [`MIPS_NBITS-1:0]  ex_instruction;
    logic [`MIPS_NBITS-1:0]  ex_registro1;
    logic [`MIPS_NBITS-1:0]  ex_registro2;
    logic [`MIPS_NBITS-1:0]  ex_extension;
    logic [`MIPS_RNBITS-1:0] ex_rt;
    logic [`MIPS_RNBITS-1:0] ex_rd;
    logic                    ex_alu_src;
    alu_op_e                 ex_alu_op;
    logic                    ex_reg_dst;

    decode_unit u_decode_unit (
        .i_instruction (i_instruction),
        .o_rs          (dec_rs),
        .o_rt          (dec_rt),
        .o_rd          (dec_rd),
        .o_extension   (dec_extension),
        .o_alu_src     (dec_alu_src),
        .o_alu_op      (dec_alu_op),
        .o_reg_dst     (dec_reg_dst),
        .o_branch      (dec_branch),
        .o_mem_write   (dec_mem_write),
        .o_mem_read    (dec_mem_read),
        .o_mem_size    (dec_mem_size),
        .o_mem_to_reg  (dec_mem_to_reg),
        .o_reg_write   (dec_reg_write)
    );

    register_file u_register_file (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rd_addr1 (dec_rs),
        .i_rd_addr2 (dec_rt),
        .i_wr_en    (i_wb_en),
        .i_wr_addr  (i_wb_addr),
        .i_wr_data  (i_wb_data),
        .o_rd_data1 (rd_data1),
        .o_rd_data2 (rd_data2)
    );

    etapa_id_ex u_etapa_id_ex (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_pc4         (i_pc4),
        .i_instruction (i_instruction),
        .i_registro1   (rd_data1),
        .i_registro2   (rd_data2),
        .i_extension   (dec_extension),
        .i_rt          (dec_rt),
        .i_rd          (dec_rd),
        .i_alu_src     (dec_alu_src),
        .i_alu_op      (dec_alu_op),
        .i_reg_dst     (dec_reg_dst),
        .i_branch      (dec_branch),
        .i_mem_write   (dec_mem_write),
        .i_mem_read    (dec_mem_read),
        .i_mem_size    (dec_mem_size),
        .i_mem_to_reg  (dec_mem_to_reg),
        .i_reg_write   (dec_reg_write),
        .o_pc4         (ex_pc4),
        .o_instruction (ex_instruction),
        .o_registro1   (ex_registro1),
        .o_registro2   (ex_registro2),
        .o_extension   (ex_extension),
        .o_rt          (ex_rt),
        .o_rd          (ex_rd),
        .o_alu_src     (ex_alu_src),
        .o_alu_op      (ex_alu_op),
        .o_reg_dst     (ex_reg_dst),
        .o_branch      (o_branch),
        .o_mem_write   (o_mem_write),
        .o_mem_read    (o_mem_read),
        .o_mem_size    (o_mem_size),
        .o_mem_to_reg  (o_mem_to_reg),
        .o_reg_write   (o_reg_write)
    );

    execute_stage u_execute_stage (
        .i_pc4           (ex_pc4),
        .i_registro1     (ex_registro1),
        .i_registro2     (ex_registro2),
        .i_extension     (ex_extension),
        .i_instruction   (ex_instruction),
        .i_rt            (ex_rt),
        .i_rd            (ex_rd),
        .i_alu_src       (ex_alu_src),
        .i_reg_dst       (ex_reg_dst),
        .i_alu_op        (ex_alu_op),
        .o_alu_result    (o_alu_result),
        .o_zero          (o_zero),
        .o_branch_target (o_branch_target),
        .o_store_data    (o_store_data),
        .o_write_reg     (o_write_reg)
    );

endmodule

`default_nettype wire

/* testbench/tb_id_ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module tb_id_ex_top
    import mips_pkg::*;
();

    localparam int N_FIRST = 8;
    localparam int N_RTYPE = 200;
    localparam int N_MEM   = 200;
    localparam int N_BEQ   = 100;
    localparam int N_UNK   = 50;

    // One cycle per issued instruction plus one per drain
    localparam int LEN_RESET   = 2 + 2 + N_FIRST + 1;
    localparam int LEN_RTYPE   = (`MIPS_NREGS - 1) + N_RTYPE + 1;
    localparam int LEN_MEM     = N_MEM + 1;
    localparam int LEN_BEQ     = N_BEQ + 1;
    localparam int LEN_UNK     = N_UNK + 1;
    localparam int LEN_ZERO    = 8;
    localparam int CYCLE_LIMIT = LEN_RESET + LEN_RTYPE + LEN_MEM + LEN_BEQ + LEN_UNK
                                 + LEN_ZERO + 50;

    localparam logic [5:0] F_ADD = 6'h20;
    localparam logic [5:0] F_SUB = 6'h22;
    localparam logic [5:0] F_AND = 6'h24;
    localparam logic [5:0] F_OR  = 6'h25;
    localparam logic [5:0] F_SLT = 6'h2A;

    // Opcode 0x3F is outside the subset
    localparam logic [31:0] NOP = 32'hFC00_0000;

    logic                    clk;
    logic                    rst_n;
    logic [`MIPS_NBITS-1:0]  instruction;
    logic [`MIPS_NBITS-1:0]  pc4;
    logic                    wb_en;
    logic [`MIPS_RNBITS-1:0] wb_addr;
    logic [`MIPS_NBITS-1:0]  wb_data;
    logic [`MIPS_NBITS-1:0]  alu_result;
    logic                    zero;
    logic [`MIPS_NBITS-1:0]  branch_target;
    logic [`MIPS_NBITS-1:0]  store_data;
    logic [`MIPS_RNBITS-1:0] write_reg;
    logic                    branch;
    logic                    mem_write;
    logic                    mem_read;
    mem_size_e               mem_size;
    logic                    mem_to_reg;
    logic                    reg_write;

    logic [`MIPS_NBITS-1:0]  model_regs [`MIPS_NREGS];
    logic [31:0]             lcg_state;
    int                      cycle_count;
    int                      test_errors;
    int                      pass_tests;
    int                      fail_tests;

    // Expected outputs of the instruction in flight
    logic                    exp_valid;
    logic                    exp_data_valid;
    logic [`MIPS_NBITS-1:0]  exp_result;
    logic                    exp_zero;
    logic [`MIPS_NBITS-1:0]  exp_target;
    logic [`MIPS_NBITS-1:0]  exp_store;
    logic [`MIPS_RNBITS-1:0] exp_wreg;
    logic                    exp_branch;
    logic                    exp_mwrite;
    logic                    exp_mread;
    mem_size_e               exp_size;
    logic                    exp_m2r;
    logic                    exp_rwrite;

    id_ex_top u_id_ex_top (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_instruction   (instruction),
        .i_pc4           (pc4),
        .i_wb_en         (wb_en),
        .i_wb_addr       (wb_addr),
        .i_wb_data       (wb_data),
        .o_alu_result    (alu_result),
        .o_zero          (zero),
        .o_branch_target (branch_target),
        .o_store_data    (store_data),
        .o_write_reg     (write_reg),
        .o_branch        (branch),
        .o_mem_write     (mem_write),
        .o_mem_read      (mem_read),
        .o_mem_size      (mem_size),
        .o_mem_to_reg    (mem_to_reg),
        .o_reg_write     (reg_write)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = next_rand();
        return r[27:23];
    endfunction

    function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [5:0] funct);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic is_known(input logic [5:0] op);
        return op inside {OP_RTYPE, OP_BEQ, OP_ADDI, OP_LB, OP_LH, OP_LW, OP_SW};
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("MISMATCH %s expected %h got %h", name, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp)
        begin
            $display("MISMATCH %s expected %h got %h", name, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("MISMATCH %s expected %h got %h", name, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_size(input string name, input mem_size_e exp, input mem_size_e act);
        if (act !== exp)
        begin
            $display("MISMATCH %s expected %h got %h", name, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    // Expected outputs from the instruction rules and the mirrored registers
    task automatic predict_outputs(input logic [31:0] instr, input logic [31:0] pc);
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  funct;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        op    = instr[31:26];
        rs    = instr[25:21];
        rt    = instr[20:16];
        rd    = instr[15:11];
        funct = instr[5:0];
        imm   = {{16{instr[15]}}, instr[15:0]};
        a     = model_regs[rs];
        b     = model_regs[rt];
        exp_data_valid = 1'b1;
        exp_branch     = 1'b0;
        exp_mwrite     = 1'b0;
        exp_mread      = 1'b0;
        exp_m2r        = 1'b0;
        exp_rwrite     = 1'b0;
        exp_size       = SIZE_BYTE;
        exp_store      = b;
        exp_target     = pc + (imm << 2);
        exp_wreg       = rt;
        exp_result     = a + imm;
        case (op)
            OP_RTYPE:
            begin
                exp_wreg   = rd;
                exp_rwrite = 1'b1;
                case (funct)
                    F_SUB:   exp_result = a - b;
                    F_AND:   exp_result = a & b;
                    F_OR:    exp_result = a | b;
                    F_SLT:   exp_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: exp_result = a + b;
                endcase
            end
            OP_ADDI:
            begin
                exp_rwrite = 1'b1;
            end
            OP_LB, OP_LH, OP_LW:
            begin
                exp_mread  = 1'b1;
                exp_m2r    = 1'b1;
                exp_rwrite = 1'b1;
                exp_size   = (op == OP_LB) ? SIZE_BYTE : (op == OP_LH) ? SIZE_HALF : SIZE_WORD;
            end
            OP_SW:
            begin
                exp_mwrite = 1'b1;
                exp_size   = SIZE_WORD;
            end
            OP_BEQ:
            begin
                exp_result = a - b;
                exp_branch = 1'b1;
            end
            default:
            begin
                // Bubble leaves only the control bits defined
                exp_data_valid = 1'b0;
            end
        endcase
        exp_zero = (exp_result == '0);
    endtask

    task automatic compare_outputs();
        check_bit("o_branch", exp_branch, branch);
        check_bit("o_mem_write", exp_mwrite, mem_write);
        check_bit("o_mem_read", exp_mread, mem_read);
        check_size("o_mem_size", exp_size, mem_size);
        check_bit("o_mem_to_reg", exp_m2r, mem_to_reg);
        check_bit("o_reg_write", exp_rwrite, reg_write);
        if (exp_data_valid)
        begin
            check_word("o_alu_result", exp_result, alu_result);
            check_bit("o_zero", exp_zero, zero);
            check_word("o_branch_target", exp_target, branch_target);
            check_word("o_store_data", exp_store, store_data);
            check_reg("o_write_reg", exp_wreg, write_reg);
        end
    endtask

    // Check the previous instruction and present the next one
    task automatic issue(input logic [31:0] instr, input logic [31:0] pc, input logic en,
                         input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        if (exp_valid)
        begin
            compare_outputs();
        end
        instruction = instr;
        pc4         = pc;
        wb_en       = en;
        wb_addr     = addr;
        wb_data     = data;
        predict_outputs(instr, pc);
        exp_valid = 1'b1;
        @(posedge clk);
        if (en && (addr != '0))
        begin
            model_regs[addr] = data;
        end
    endtask

    task automatic drain();
        @(negedge clk);
        if (exp_valid)
        begin
            compare_outputs();
        end
        exp_valid   = 1'b0;
        wb_en       = 1'b0;
        instruction = NOP;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0)
        begin
            $display("%s: ok", name);
            pass_tests = pass_tests + 1;
        end
        else
        begin
            $display("%s: FAILED with %0d errors", name, test_errors);
            fail_tests = fail_tests + 1;
        end
        test_errors = 0;
    endtask

    task automatic run_reset_state();
        // ID/EX still holds its reset contents at the release edge
        check_bit("o_branch", 1'b0, branch);
        check_bit("o_mem_write", 1'b0, mem_write);
        check_bit("o_mem_read", 1'b0, mem_read);
        check_size("o_mem_size", SIZE_BYTE, mem_size);
        check_bit("o_mem_to_reg", 1'b0, mem_to_reg);
        check_bit("o_reg_write", 1'b0, reg_write);
        for (int i = 0; i < N_FIRST; i++)
        begin
            issue(encode_r(rand_reg(), rand_reg(), rand_reg(), F_ADD), 32'h4, 1'b0, '0, '0);
        end
        drain();
        finish_test("reset_state");
    endtask

    task automatic run_rtype();
        logic [31:0] r;
        logic [5:0]  funct;
        for (int i = 1; i < `MIPS_NREGS; i++)
        begin
            issue(NOP, 32'h0, 1'b1, i[4:0], next_rand());
        end
        for (int i = 0; i < N_RTYPE; i++)
        begin
            r = next_rand();
            case (r[10:8])
                3'd0:    funct = F_ADD;
                3'd1:    funct = F_SUB;
                3'd2:    funct = F_AND;
                3'd3:    funct = F_OR;
                3'd4:    funct = F_SLT;
                default: funct = r[21:16];
            endcase
            issue(encode_r(rand_reg(), rand_reg(), rand_reg(), funct), {r[31:2], 2'b00},
                  r[3:2] == 2'b00, rand_reg(), next_rand());
        end
        drain();
        finish_test("random_rtype");
    endtask

    task automatic run_mem();
        logic [31:0] r;
        logic [5:0]  op;
        for (int i = 0; i < N_MEM; i++)
        begin
            r = next_rand();
            case (r[9:7])
                3'd0, 3'd5: op = OP_ADDI;
                3'd1, 3'd6: op = OP_LB;
                3'd2, 3'd7: op = OP_LH;
                3'd3:       op = OP_LW;
                default:    op = OP_SW;
            endcase
            issue(encode_i(op, rand_reg(), rand_reg(), r[31:16]), 32'h100, 1'b0, '0, '0);
        end
        drain();
        finish_test("addi_load_store");
    endtask

    task automatic run_beq();
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        for (int i = 0; i < N_BEQ; i++)
        begin
            r  = next_rand();
            rs = rand_reg();
            // A high bit, the low bit of the LCG only alternates
            rt = r[20] ? rs : rand_reg();
            issue(encode_i(OP_BEQ, rs, rt, r[23:8]), {next_rand() & 32'hFFFF_FFFC},
                  1'b0, '0, '0);
        end
        drain();
        finish_test("beq");
    endtask

    task automatic run_unknown();
        logic [31:0] r;
        logic [5:0]  op;
        for (int i = 0; i < N_UNK; i++)
        begin
            do
            begin
                r  = next_rand();
                op = r[29:24];
            end
            while (is_known(op));
            issue({op, r[25:0]}, 32'h200, 1'b0, '0, '0);
        end
        drain();
        finish_test("unknown_opcode");
    endtask

    task automatic run_reg_zero();
        issue(NOP, 32'h0, 1'b1, 5'd0, 32'hDEAD_BEEF);
        issue(encode_r(5'd0, 5'd0, 5'd3, F_ADD), 32'h4, 1'b0, '0, '0);
        issue(encode_r(5'd0, 5'd0, 5'd4, F_OR), 32'h8, 1'b1, 5'd0, 32'hFFFF_FFFF);
        issue(encode_i(OP_ADDI, 5'd0, 5'd5, 16'h0000), 32'hC, 1'b0, '0, '0);
        // Same-cycle write and read of r9 sees the old value
        issue(encode_r(5'd9, 5'd0, 5'd1, F_ADD), 32'h10, 1'b1, 5'd9, 32'h0BAD_F00D);
        issue(encode_r(5'd9, 5'd0, 5'd1, F_ADD), 32'h14, 1'b0, '0, '0);
        drain();
        finish_test("register_zero");
    endtask

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        instruction = '0;
        pc4         = '0;
        wb_en       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        lcg_state   = 32'd32916;
        cycle_count = 0;
        test_errors = 0;
        pass_tests  = 0;
        fail_tests  = 0;
        exp_valid   = 1'b0;
        for (int i = 0; i < `MIPS_NREGS; i++)
        begin
            model_regs[i] = '0;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        run_reset_state();
        run_rtype();
        run_mem();
        run_beq();
        run_unknown();
        run_reg_zero();

        $display("tests ok %0d, tests failing %0d", pass_tests, fail_tests);
        if (fail_tests == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/mips_pkg.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/etapa_id_ex.sv
hdl/execute_stage.sv
hdl/id_ex_top.sv
testbench/tb_id_ex_top.sv

/* Bender.yml */
package:
  name: id_ex_pipeline

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/mips_pkg.sv
      - hdl/decode_unit.sv
      - hdl/register_file.sv
      - hdl/etapa_id_ex.sv
      - hdl/execute_stage.sv
      - hdl/id_ex_top.sv
  - target: test
    files:
      - testbench/tb_id_ex_top.sv
